// File: hdl/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

    // Control bus widths
    localparam int NB_WB_BUS   = 2;
    localparam int NB_MEM_BUS  = 3;
    localparam int NB_EXC_BUS  = 2;
    localparam int NB_ALU_CODE = 4;

    // Width of the register and shift fields of the instruction word
    localparam int NB_REG_FIELD = 5;

    // Write-back bus bits
    localparam int WB_REG_WRITE  = 1;
    localparam int WB_MEM_TO_REG = 0;

    // Memory bus bits
    localparam int MEM_BRANCH = 2;
    localparam int MEM_READ   = 1;
    localparam int MEM_WRITE  = 0;

    // Execute bus bits
    localparam int EXC_REG_DST = 1;
    localparam int EXC_ALU_SRC = 0;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;
    localparam logic [5:0] FN_SLL = 6'h00;

    localparam logic [3:0] ALU_AND = 4'b0000;
    localparam logic [3:0] ALU_OR  = 4'b0001;
    localparam logic [3:0] ALU_ADD = 4'b0010;
    localparam logic [3:0] ALU_SLL = 4'b0011;
    localparam logic [3:0] ALU_LUI = 4'b0100;
    localparam logic [3:0] ALU_SUB = 4'b0110;
    localparam logic [3:0] ALU_SLT = 4'b0111;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [NB_REG_FIELD-1:0] rs;
        logic [NB_REG_FIELD-1:0] rt;
        logic [NB_REG_FIELD-1:0] rd;
        logic [NB_REG_FIELD-1:0] shamt;
        logic [5:0]              funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [NB_REG_FIELD-1:0] rs;
        logic [NB_REG_FIELD-1:0] rt;
        logic [15:0]             imm;
    } instr_i_t;

    // Same 32-bit word, read as R-format or I-format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

`default_nettype wire

// File: hdl/main_control.sv
`default_nettype none

module main_control
    import mips_decode_pkg::*;
(
    input  wire  [5:0]             i_opcode,
    input  wire  [5:0]             i_funct,
    output logic [NB_WB_BUS-1:0]   o_wb_bus,
    output logic [NB_MEM_BUS-1:0]  o_mem_bus,
    output logic [NB_EXC_BUS-1:0]  o_exc_bus,
    output logic [NB_ALU_CODE-1:0] o_alu_code
);

    logic [3:0] rtype_alu_code;
    logic       rtype_known;

    // R-type operation from funct
    always_comb begin
        rtype_known    = 1'b1;
        rtype_alu_code = ALU_ADD;
        case (i_funct)
            FN_ADD: rtype_alu_code = ALU_ADD;
            FN_SUB: rtype_alu_code = ALU_SUB;
            FN_AND: rtype_alu_code = ALU_AND;
            FN_OR:  rtype_alu_code = ALU_OR;
            FN_SLT: rtype_alu_code = ALU_SLT;
            FN_SLL: rtype_alu_code = ALU_SLL;
            default: begin
                rtype_known    = 1'b0;
                rtype_alu_code = '0;
            end
        endcase
    end

    always_comb begin
        // Bubble unless decoded below
        o_wb_bus   = '0;
        o_mem_bus  = '0;
        o_exc_bus  = '0;
        o_alu_code = '0;

        case (i_opcode)
            OP_RTYPE: begin
                if (rtype_known) begin
                    o_wb_bus[WB_REG_WRITE]  = 1'b1;
                    o_exc_bus[EXC_REG_DST]  = 1'b1;
                    o_alu_code              = rtype_alu_code;
                end
            end
            OP_LW: begin
                o_wb_bus[WB_REG_WRITE]  = 1'b1;
                o_wb_bus[WB_MEM_TO_REG] = 1'b1;
                o_mem_bus[MEM_READ]     = 1'b1;
                o_exc_bus[EXC_ALU_SRC]  = 1'b1;
                o_alu_code              = ALU_ADD;
            end
            OP_SW: begin
                o_mem_bus[MEM_WRITE]   = 1'b1;
                o_exc_bus[EXC_ALU_SRC] = 1'b1;
                o_alu_code             = ALU_ADD;
            end
            OP_BEQ: begin
                o_mem_bus[MEM_BRANCH] = 1'b1;
                o_alu_code            = ALU_SUB;
            end
            OP_ADDI: begin
                o_wb_bus[WB_REG_WRITE] = 1'b1;
                o_exc_bus[EXC_ALU_SRC] = 1'b1;
                o_alu_code             = ALU_ADD;
            end
            OP_SLTI: begin
                o_wb_bus[WB_REG_WRITE] = 1'b1;
                o_exc_bus[EXC_ALU_SRC] = 1'b1;
                o_alu_code             = ALU_SLT;
            end
            OP_ANDI: begin
                o_wb_bus[WB_REG_WRITE] = 1'b1;
                o_exc_bus[EXC_ALU_SRC] = 1'b1;
                o_alu_code             = ALU_AND;
            end
            OP_ORI: begin
                o_wb_bus[WB_REG_WRITE] = 1'b1;
                o_exc_bus[EXC_ALU_SRC] = 1'b1;
                o_alu_code             = ALU_OR;
            end
            OP_LUI: begin
                o_wb_bus[WB_REG_WRITE] = 1'b1;
                o_exc_bus[EXC_ALU_SRC] = 1'b1;
                o_alu_code             = ALU_LUI;
            end
            default: begin
                o_alu_code = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`default_nettype none

module register_file #(
    parameter int NB_DATA = 32,
    parameter int NB_ADDR = 5
) (
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire                i_reg_write,
    input  wire  [NB_ADDR-1:0] i_read_register_1,
    input  wire  [NB_ADDR-1:0] i_read_register_2,
    input  wire  [NB_ADDR-1:0] i_write_register,
    input  wire  [NB_DATA-1:0] i_write_data,
    output logic [NB_DATA-1:0] o_read_data_1,
    output logic [NB_DATA-1:0] o_read_data_2
);

    localparam int N_REGS = 2 ** NB_ADDR;

    logic [NB_DATA-1:0] regs [N_REGS];
    logic               write_en;

    // r0 is never written
    assign write_en = i_reg_write && (i_write_register != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[i_write_register] <= i_write_data;
        end
    end

    // Zero masking, then same-cycle bypass of the write data
    function automatic logic [NB_DATA-1:0] read_port(input logic [NB_ADDR-1:0] addr);
        logic [NB_DATA-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (write_en && (addr == i_write_register)) begin
            data = i_write_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_read_data_1 = read_port(i_read_register_1);
        o_read_data_2 = read_port(i_read_register_2);
    end

endmodule

`default_nettype wire

// File: hdl/instruction_decode.sv
`default_nettype none

module instruction_decode
    import mips_decode_pkg::*;
#(
    parameter int NB_DATA = 32,
    parameter int NB_ADDR = 5
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire  instr_u            i_instruc,
    input  wire                     i_wb_reg_write,
    input  wire  [NB_ADDR-1:0]      i_wb_write_register,
    input  wire  [NB_DATA-1:0]      i_wb_write_data,
    output logic [NB_WB_BUS-1:0]    o_wb_bus,
    output logic [NB_MEM_BUS-1:0]   o_mem_bus,
    output logic [NB_EXC_BUS-1:0]   o_exc_bus,
    output logic [NB_ALU_CODE-1:0]  o_alu_code,
    output logic [NB_DATA-1:0]      o_read_data_1,
    output logic [NB_DATA-1:0]      o_read_data_2,
    output logic [NB_DATA-1:0]      o_imm_ext,
    output logic [NB_REG_FIELD-1:0] o_shamt,
    output logic [NB_ADDR-1:0]      o_write_register
);

    localparam int NB_IMM = 16;

    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [NB_ADDR-1:0] rs;
    logic [NB_ADDR-1:0] rt;
    logic [NB_ADDR-1:0] rd;
    logic [NB_IMM-1:0]  imm;

    // Register fields from the R view, immediate from the I view
    assign opcode  = i_instruc.r.opcode;
    assign funct   = i_instruc.r.funct;
    assign rs      = i_instruc.r.rs;
    assign rt      = i_instruc.r.rt;
    assign rd      = i_instruc.r.rd;
    assign o_shamt = i_instruc.r.shamt;
    assign imm     = i_instruc.i.imm;

    // reg_dst high selects rd
    assign o_write_register = o_exc_bus[EXC_REG_DST] ? rd : rt;

    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI: o_imm_ext = {{(NB_DATA-NB_IMM){1'b0}}, imm};
            OP_LUI:          o_imm_ext = {imm, {(NB_DATA-NB_IMM){1'b0}}};
            default:         o_imm_ext = {{(NB_DATA-NB_IMM){imm[NB_IMM-1]}}, imm};
        endcase
    end

    main_control u_control (
        .i_opcode   (opcode),
        .i_funct    (funct),
        .o_wb_bus   (o_wb_bus),
        .o_mem_bus  (o_mem_bus),
        .o_exc_bus  (o_exc_bus),
        .o_alu_code (o_alu_code)
    );

    // Writes come from the write-back stage, not from this instruction
    register_file #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) u_registers (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_reg_write       (i_wb_reg_write),
        .i_read_register_1 (rs),
        .i_read_register_2 (rt),
        .i_write_register  (i_wb_write_register),
        .i_write_data      (i_wb_write_data),
        .o_read_data_1     (o_read_data_1),
        .o_read_data_2     (o_read_data_2)
    );

endmodule

`default_nettype wire

// File: hdl/id_ex_register.sv
`default_nettype none

module id_ex_register
    import mips_decode_pkg::*;
#(
    parameter int NB_DATA = 32
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_valid,
    input  wire  [NB_WB_BUS-1:0]    i_wb_bus,
    input  wire  [NB_MEM_BUS-1:0]   i_mem_bus,
    input  wire  [NB_EXC_BUS-1:0]   i_exc_bus,
    input  wire  [NB_ALU_CODE-1:0]  i_alu_code,
    input  wire  [NB_DATA-1:0]      i_read_data_1,
    input  wire  [NB_DATA-1:0]      i_read_data_2,
    input  wire  [NB_DATA-1:0]      i_imm_ext,
    input  wire  [NB_REG_FIELD-1:0] i_shamt,
    input  wire  [NB_REG_FIELD-1:0] i_write_register,
    output logic                    o_valid,
    output logic [NB_WB_BUS-1:0]    o_wb_bus,
    output logic [NB_MEM_BUS-1:0]   o_mem_bus,
    output logic [NB_EXC_BUS-1:0]   o_exc_bus,
    output logic [NB_ALU_CODE-1:0]  o_alu_code,
    output logic [NB_DATA-1:0]      o_read_data_1,
    output logic [NB_DATA-1:0]      o_read_data_2,
    output logic [NB_DATA-1:0]      o_imm_ext,
    output logic [NB_REG_FIELD-1:0] o_shamt,
    output logic [NB_REG_FIELD-1:0] o_write_register
);

    // Control: a bubble on reset or an empty slot
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_wb_bus   <= '0;
            o_mem_bus  <= '0;
            o_exc_bus  <= '0;
            o_alu_code <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_wb_bus   <= i_wb_bus;
                o_mem_bus  <= i_mem_bus;
                o_exc_bus  <= i_exc_bus;
                o_alu_code <= i_alu_code;
            end else begin
                o_wb_bus   <= '0;
                o_mem_bus  <= '0;
                o_exc_bus  <= '0;
                o_alu_code <= '0;
            end
        end
    end

    // Payload
    always_ff @(posedge i_clk) begin
        o_read_data_1    <= i_read_data_1;
        o_read_data_2    <= i_read_data_2;
        o_imm_ext        <= i_imm_ext;
        o_shamt          <= i_shamt;
        o_write_register <= i_write_register;
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage_top.sv
`default_nettype none

module decode_stage_top
    import mips_decode_pkg::*;
#(
    parameter int NB_DATA = 32,
    parameter int NB_ADDR = 5
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_valid,
    input  wire  instr_u            i_instruc,
    input  wire                     i_wb_reg_write,
    input  wire  [NB_ADDR-1:0]      i_wb_write_register,
    input  wire  [NB_DATA-1:0]      i_wb_write_data,
    output logic                    o_valid,
    output logic [NB_WB_BUS-1:0]    o_wb_bus,
    output logic [NB_MEM_BUS-1:0]   o_mem_bus,
    output logic [NB_EXC_BUS-1:0]   o_exc_bus,
    output logic [NB_ALU_CODE-1:0]  o_alu_code,
    output logic [NB_DATA-1:0]      o_read_data_1,
    output logic [NB_DATA-1:0]      o_read_data_2,
    output logic [NB_DATA-1:0]      o_imm_ext,
    output logic [NB_REG_FIELD-1:0] o_shamt,
    output logic [NB_ADDR-1:0]      o_write_register
);

    logic [NB_WB_BUS-1:0]    id_wb_bus;
    logic [NB_MEM_BUS-1:0]   id_mem_bus;
    logic [NB_EXC_BUS-1:0]   id_exc_bus;
    logic [NB_ALU_CODE-1:0]  id_alu_code;
    logic [NB_DATA-1:0]      id_read_data_1;
    logic [NB_DATA-1:0]      id_read_data_2;
    logic [NB_DATA-1:0]      id_imm_ext;
    logic [NB_REG_FIELD-1:0] id_shamt;
    logic [NB_ADDR-1:0]      id_write_register;

    instruction_decode #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) u_decode (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_instruc           (i_instruc),
        .i_wb_reg_write      (i_wb_reg_write),
        .i_wb_write_register (i_wb_write_register),
        .i_wb_write_data     (i_wb_write_data),
        .o_wb_bus            (id_wb_bus),
        .o_mem_bus           (id_mem_bus),
        .o_exc_bus           (id_exc_bus),
        .o_alu_code          (id_alu_code),
        .o_read_data_1       (id_read_data_1),
        .o_read_data_2       (id_read_data_2),
        .o_imm_ext           (id_imm_ext),
        .o_shamt             (id_shamt),
        .o_write_register    (id_write_register)
    );

    id_ex_register #(
        .NB_DATA (NB_DATA)
    ) u_id_ex (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_valid          (i_valid),
        .i_wb_bus         (id_wb_bus),
        .i_mem_bus        (id_mem_bus),
        .i_exc_bus        (id_exc_bus),
        .i_alu_code       (id_alu_code),
        .i_read_data_1    (id_read_data_1),
        .i_read_data_2    (id_read_data_2),
        .i_imm_ext        (id_imm_ext),
        .i_shamt          (id_shamt),
        .i_write_register (id_write_register),
        .o_valid          (o_valid),
        .o_wb_bus         (o_wb_bus),
        .o_mem_bus        (o_mem_bus),
        .o_exc_bus        (o_exc_bus),
        .o_alu_code       (o_alu_code),
        .o_read_data_1    (o_read_data_1),
        .o_read_data_2    (o_read_data_2),
        .o_imm_ext        (o_imm_ext),
        .o_shamt          (o_shamt),
        .o_write_register (o_write_register)
    );

endmodule

`default_nettype wire

// File: verification/decode_stage_model.svh
`ifndef DECODE_STAGE_MODEL_SVH
`define DECODE_STAGE_MODEL_SVH

    // Expected control as {wb[1:0], mem[2:0], exc[1:0], alu[3:0]}
    function automatic logic [10:0] decode_control(input logic [31:0] instr);
        logic [1:0] wb;
        logic [2:0] mem;
        logic [1:0] exc;
        logic [3:0] alu;
        wb  = 2'b00;
        mem = 3'b000;
        exc = 2'b00;
        alu = 4'b0000;
        case (instr[31:26])
            OP_RTYPE: begin
                wb  = 2'b10;
                exc = 2'b10;
                case (instr[5:0])
                    FN_ADD: alu = ALU_ADD;
                    FN_SUB: alu = ALU_SUB;
                    FN_AND: alu = ALU_AND;
                    FN_OR:  alu = ALU_OR;
                    FN_SLT: alu = ALU_SLT;
                    FN_SLL: alu = ALU_SLL;
                    default: begin
                        wb  = 2'b00;
                        exc = 2'b00;
                    end
                endcase
            end
            OP_LW: begin
                wb  = 2'b11;
                mem = 3'b010;
                exc = 2'b01;
                alu = ALU_ADD;
            end
            OP_SW: begin
                mem = 3'b001;
                exc = 2'b01;
                alu = ALU_ADD;
            end
            OP_BEQ: begin
                mem = 3'b100;
                alu = ALU_SUB;
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                wb  = 2'b10;
                exc = 2'b01;
                case (instr[31:26])
                    OP_ADDI: alu = ALU_ADD;
                    OP_SLTI: alu = ALU_SLT;
                    OP_ANDI: alu = ALU_AND;
                    OP_ORI:  alu = ALU_OR;
                    default: alu = ALU_LUI;
                endcase
            end
            default: begin
                alu = 4'b0000;
            end
        endcase
        return {wb, mem, exc, alu};
    endfunction

    function automatic logic [31:0] extend_immediate(input logic [31:0] instr);
        if (instr[31:26] == OP_ANDI || instr[31:26] == OP_ORI) begin
            return {16'h0000, instr[15:0]};
        end else if (instr[31:26] == OP_LUI) begin
            return {instr[15:0], 16'h0000};
        end
        return {{16{instr[15]}}, instr[15:0]};
    endfunction

    // rd when reg_dst is set, rt otherwise
    function automatic logic [4:0] select_destination(input logic [31:0] instr);
        logic [10:0] ctrl;
        ctrl = decode_control(instr);
        return ctrl[5] ? instr[15:11] : instr[20:16];
    endfunction

`endif

// File: verification/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb
    import mips_decode_pkg::*;
();

    localparam int NB_DATA        = 32;
    localparam int NB_ADDR        = 5;
    localparam int CLK_PERIOD     = 40;
    localparam int SEED           = 7197;
    localparam int TIMEOUT_CYCLES = 8;

    logic               i_clk;
    logic               i_rst_n;
    logic               i_valid;
    logic [31:0]        i_instruc;
    logic               i_wb_reg_write;
    logic [NB_ADDR-1:0] i_wb_write_register;
    logic [NB_DATA-1:0] i_wb_write_data;
    logic               o_valid;
    logic [1:0]         o_wb_bus;
    logic [2:0]         o_mem_bus;
    logic [1:0]         o_exc_bus;
    logic [3:0]         o_alu_code;
    logic [NB_DATA-1:0] o_read_data_1;
    logic [NB_DATA-1:0] o_read_data_2;
    logic [NB_DATA-1:0] o_imm_ext;
    logic [4:0]         o_shamt;
    logic [NB_ADDR-1:0] o_write_register;

    logic [NB_DATA-1:0] shadow [32];
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    int                 test_start_errors;
    string              test_name;

    `include "decode_stage_model.svh"

    decode_stage_top #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) UUT (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_valid             (i_valid),
        .i_instruc           (i_instruc),
        .i_wb_reg_write      (i_wb_reg_write),
        .i_wb_write_register (i_wb_write_register),
        .i_wb_write_data     (i_wb_write_data),
        .o_valid             (o_valid),
        .o_wb_bus            (o_wb_bus),
        .o_mem_bus           (o_mem_bus),
        .o_exc_bus           (o_exc_bus),
        .o_alu_code          (o_alu_code),
        .o_read_data_1       (o_read_data_1),
        .o_read_data_2       (o_read_data_2),
        .o_imm_ext           (o_imm_ext),
        .o_shamt             (o_shamt),
        .o_write_register    (o_write_register)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s expected %h actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    // Output must settle one cycle after the sampling edge
    task automatic wait_output(input logic exp_valid);
        int cycles;
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
        end while (o_valid !== exp_valid && cycles < TIMEOUT_CYCLES);
        if (o_valid !== exp_valid) begin
            $display("Timeout in %s: o_valid never became %b", test_name, exp_valid);
            $display("test failed");
            $finish;
        end else begin
            assert (cycles == 1) else begin
                $display("Latency error in %s: output took %0d cycles", test_name, cycles);
                errors++;
            end
        end
    endtask

    task automatic run_slot(input logic valid, input logic [31:0] instr, input logic wb_we,
                            input logic [4:0] wb_reg, input logic [31:0] wb_data);
        logic [10:0] ctrl;
        logic [31:0] exp_rd1;
        logic [31:0] exp_rd2;
        @(posedge i_clk);
        i_valid             <= valid;
        i_instruc           <= instr;
        i_wb_reg_write      <= wb_we;
        i_wb_write_register <= wb_reg;
        i_wb_write_data     <= wb_data;
        // Same-cycle write is visible through the bypass
        if (wb_we && wb_reg != 5'd0) begin
            shadow[wb_reg] = wb_data;
        end
        ctrl    = valid ? decode_control(instr) : 11'd0;
        exp_rd1 = shadow[instr[25:21]];
        exp_rd2 = shadow[instr[20:16]];
        @(posedge i_clk);
        wait_output(valid);
        check_value("o_wb_bus", ctrl[10:9], o_wb_bus);
        check_value("o_mem_bus", ctrl[8:6], o_mem_bus);
        check_value("o_exc_bus", ctrl[5:4], o_exc_bus);
        check_value("o_alu_code", ctrl[3:0], o_alu_code);
        if (valid) begin
            check_value("o_read_data_1", exp_rd1, o_read_data_1);
            check_value("o_read_data_2", exp_rd2, o_read_data_2);
            check_value("o_imm_ext", extend_immediate(instr), o_imm_ext);
            check_value("o_shamt", instr[10:6], o_shamt);
            check_value("o_write_register", select_destination(instr), o_write_register);
        end
    endtask

    // Kinds 0-5 R-type, 6-13 I-type, 14 unknown opcode, 15 unknown funct
    function automatic logic [31:0] random_instr(input int kind);
        logic [31:0] word;
        logic [31:0] rnd;
        word = $urandom;
        case (kind)
            0:  word = {OP_RTYPE, word[25:6], FN_ADD};
            1:  word = {OP_RTYPE, word[25:6], FN_SUB};
            2:  word = {OP_RTYPE, word[25:6], FN_AND};
            3:  word = {OP_RTYPE, word[25:6], FN_OR};
            4:  word = {OP_RTYPE, word[25:6], FN_SLT};
            5:  word = {OP_RTYPE, word[25:6], FN_SLL};
            6:  word[31:26] = OP_ADDI;
            7:  word[31:26] = OP_SLTI;
            8:  word[31:26] = OP_ANDI;
            9:  word[31:26] = OP_ORI;
            10: word[31:26] = OP_LUI;
            11: word[31:26] = OP_LW;
            12: word[31:26] = OP_SW;
            13: word[31:26] = OP_BEQ;
            14: begin
                do begin
                    rnd = $urandom;
                    word[31:26] = rnd[5:0];
                end while (word[31:26] == OP_RTYPE || decode_control(word) != 11'd0);
            end
            default: begin
                word[31:26] = OP_RTYPE;
                do begin
                    rnd = $urandom;
                    word[5:0] = rnd[5:0];
                end while (decode_control(word) != 11'd0);
            end
        endcase
        return word;
    endfunction

    task automatic begin_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic end_test;
        tests_run++;
        if (errors == test_start_errors) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s", test_name);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] instr;
        logic [4:0]  reg_n;
        void'($urandom(SEED));
        errors              = 0;
        tests_run           = 0;
        tests_failed        = 0;
        i_rst_n             = 1'b0;
        // A valid load held during reset must still come out as a bubble
        i_valid             = 1'b1;
        i_instruc           = {OP_LW, 5'd1, 5'd2, 16'h0004};
        i_wb_reg_write      = 1'b0;
        i_wb_write_register = '0;
        i_wb_write_data     = '0;
        for (int n = 0; n < 32; n++) begin
            shadow[n] = '0;
        end
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        i_valid <= 1'b0;

        begin_test("reset_state");
        @(negedge i_clk);
        check_value("o_valid", 32'd0, o_valid);
        check_value("o_wb_bus", 32'd0, o_wb_bus);
        check_value("o_mem_bus", 32'd0, o_mem_bus);
        check_value("o_exc_bus", 32'd0, o_exc_bus);
        check_value("o_alu_code", 32'd0, o_alu_code);
        for (int n = 0; n < 32; n++) begin
            instr = {OP_RTYPE, 5'(n), 5'(31 - n), 5'd1, 5'd0, FN_ADD};
            run_slot(1'b1, instr, 1'b0, 5'd0, 32'd0);
        end
        end_test();

        // Writes to every register, r0 included, then reads back
        begin_test("register_read");
        for (int n = 0; n < 32; n++) begin
            run_slot(1'b1, random_instr(0), 1'b1, 5'(n), $urandom);
        end
        for (int n = 0; n < 32; n++) begin
            rnd   = $urandom;
            instr = {OP_RTYPE, 5'(n), rnd[4:0], 5'd3, 5'd0, FN_OR};
            run_slot(1'b1, instr, 1'b0, 5'd0, 32'd0);
        end
        end_test();

        begin_test("write_bypass");
        for (int n = 0; n < 16; n++) begin
            reg_n = (n == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            instr = {OP_RTYPE, reg_n, reg_n, 5'd2, 5'd0, FN_SUB};
            run_slot(1'b1, instr, 1'b1, reg_n, ~shadow[reg_n]);
        end
        end_test();

        begin_test("control_decode");
        for (int n = 0; n < 300; n++) begin
            run_slot(1'b1, random_instr($urandom_range(15, 0)), 1'b0, 5'd0, 32'd0);
        end
        end_test();

        // Immediate corner values for every I-type kind, then R-type fields
        begin_test("immediate_and_fields");
        for (int kind = 6; kind < 14; kind++) begin
            instr = random_instr(kind);
            run_slot(1'b1, {instr[31:16], 16'h8000}, 1'b0, 5'd0, 32'd0);
            run_slot(1'b1, {instr[31:16], 16'h7fff}, 1'b0, 5'd0, 32'd0);
            run_slot(1'b1, {instr[31:16], 16'hffff}, 1'b0, 5'd0, 32'd0);
        end
        for (int n = 0; n < 24; n++) begin
            run_slot(1'b1, random_instr(n % 6), 1'b0, 5'd0, 32'd0);
        end
        end_test();

        begin_test("invalid_slot");
        for (int n = 0; n < 20; n++) begin
            run_slot(1'b1, random_instr($urandom_range(13, 0)), 1'b0, 5'd0, 32'd0);
            run_slot(1'b0, random_instr(n % 2 ? 11 : 6), 1'b0, 5'd0, 32'd0);
        end
        end_test();

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: decode_stage_top.f
+incdir+verification
hdl/mips_decode_pkg.sv
hdl/main_control.sv
hdl/register_file.sv
hdl/instruction_decode.sv
hdl/id_ex_register.sv
hdl/decode_stage_top.sv
verification/decode_stage_tb.sv
